/* bench/cache_tb.sv */
module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_banks = 2;
    localparam int mshr_depth = 4;
    localparam int us = cache_pkg::uuid_size;
    localparam int num_requests = 400;
    localparam int flush_cycles = 100;
    localparam int timeout_cycles = num_requests * 6 + flush_cycles;
    localparam int hold_start = 150;
    localparam int hold_end = 190;
    localparam logic [31:0] base_addr = 32'h0004_0000;
    localparam logic [31:0] fill_key = 32'h3c5a_96e1;

    typedef struct packed {
        logic [31:0] addr;
        logic rw;
        logic [31:0] data;
        logic [us-1:0] uuid;
    } pend_t;

    logic CLK;
    logic reset;
    logic mem_in;
    logic [31:0] mem_in_addr;
    logic mem_in_rw_mode;
    logic [31:0] mem_in_store_value;
    logic dp_in_halt;
    logic [us-1:0] mem_out_uuid;
    logic stall;
    logic hit;
    logic [31:0] hit_load;
    logic [num_banks-1:0] block_status;
    logic [num_banks-1:0][us-1:0] uuid_block;
    logic [num_banks-1:0][31:0] fill_load;
    logic dp_out_flushed;
    logic [num_banks-1:0] ram_mem_ren;
    logic [num_banks-1:0] ram_mem_wen;
    logic [num_banks-1:0][31:0] ram_mem_addr;
    logic [num_banks-1:0][31:0] ram_mem_store;
    logic [num_banks-1:0][31:0] ram_mem_data;
    logic [num_banks-1:0] ram_mem_complete;
    logic [num_banks-1:0] hold;

    int errors = 0;
    int ram_errors;
    int cycles = 0;
    logic was_dropped = 1'b0;
    logic [31:0] lfsr_state = 32'hb348_04d0;
    logic [us-1:0] next_uuid [num_banks] = '{default: '0};
    logic [31:0] shadow [64];
    pend_t pend_q [num_banks][$];

    lockup_free_cache #(.num_banks(num_banks), .mshr_depth(mshr_depth)) lockup_free_cache_i (.*);

    ram_model #(.num_banks(num_banks), .fill_key(fill_key)) ram_model_i (
        .CLK(CLK), .reset(reset), .hold(hold),
        .ram_mem_ren(ram_mem_ren), .ram_mem_wen(ram_mem_wen),
        .ram_mem_addr(ram_mem_addr), .ram_mem_store(ram_mem_store),
        .ram_mem_data(ram_mem_data), .ram_mem_complete(ram_mem_complete),
        .errors(ram_errors)
    );

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // The window is 64 words starting at base_addr
    function automatic int window_index(input logic [31:0] addr);
        return int'((addr - base_addr) >> 2);
    endfunction

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic drive_request(input logic to_bank1);
        logic [31:0] addr;
        if (take_bits(3) == 0) begin
            mem_in <= 1'b0;
        end else begin
            addr = base_addr | (take_bits(6) << 2);
            if (to_bank1) begin
                addr[cache_pkg::byte_off_bits] = 1'b1;
            end
            mem_in <= 1'b1;
            mem_in_addr <= addr;
            mem_in_rw_mode <= (take_bits(2) == 0);
            mem_in_store_value <= take_bits(32);
        end
    endtask

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic check_bank(input int b);
        pend_t p;
        if (ram_mem_ren[b] || ram_mem_wen[b]) begin
            if (pend_q[b].size() == 0) begin
                errors++;
                $display("RAM strobe on bank %0d with no request pending", b);
            end else begin
                p = pend_q[b][0];
                assert (ram_mem_wen[b] == p.rw) else begin
                    errors++;
                    $display("FAIL ram_mem_wen[%0d]: got %h expected %h", b, ram_mem_wen[b], p.rw);
                end
                assert (ram_mem_addr[b] == p.addr) else begin
                    errors++;
                    $display("FAIL ram_mem_addr[%0d]: got %h expected %h",
                             b, ram_mem_addr[b], p.addr);
                end
                if (p.rw) begin
                    assert (ram_mem_store[b] == p.data) else begin
                        errors++;
                        $display("FAIL ram_mem_store[%0d]: got %h expected %h",
                                 b, ram_mem_store[b], p.data);
                    end
                end
            end
        end
        if (block_status[b]) begin
            if (pend_q[b].size() == 0) begin
                errors++;
                $display("Completion pulse on bank %0d with nothing pending", b);
            end else begin
                p = pend_q[b].pop_front();
                assert (uuid_block[b] == p.uuid) else begin
                    errors++;
                    $display("FAIL uuid_block[%0d]: got %h expected %h", b, uuid_block[b], p.uuid);
                end
                if (!p.rw) begin
                    assert (fill_load[b] == p.data) else begin
                        errors++;
                        $display("FAIL fill_load[%0d] @%h: got %h expected %h",
                                 b, p.addr, fill_load[b], p.data);
                    end
                end
            end
        end
        if (dp_out_flushed) begin
            assert (pend_q[b].size() == 0) else begin
                errors++;
                $display("Flushed raised with %0d completions due on bank %0d",
                         pend_q[b].size(), b);
            end
        end
    endtask

    task automatic record_request();
        int b;
        int w;
        pend_t p;
        b = int'(mem_in_addr[cache_pkg::byte_off_bits +: cache_pkg::banks_len]);
        w = window_index(mem_in_addr);
        was_dropped = mem_in && stall;
        if (mem_in && hit) begin
            assert (!mem_in_rw_mode) else begin
                errors++;
                $display("A write was reported as a hit");
            end
            assert (hit_load == shadow[w]) else begin
                errors++;
                $display("FAIL hit_load @%h: got %h expected %h", mem_in_addr, hit_load, shadow[w]);
            end
        end else if (mem_in) begin
            // A stalled request must leave the tag where it was
            assert (mem_out_uuid == next_uuid[b]) else begin
                errors++;
                $display("FAIL mem_out_uuid: got %h expected %h", mem_out_uuid, next_uuid[b]);
            end
            if (!stall) begin
                p.addr = mem_in_addr;
                p.rw = mem_in_rw_mode;
                p.data = mem_in_rw_mode ? mem_in_store_value : shadow[w];
                p.uuid = next_uuid[b];
                pend_q[b].push_back(p);
                next_uuid[b] = next_uuid[b] + 1'b1;
                if (mem_in_rw_mode) begin
                    shadow[w] = mem_in_store_value;
                end
            end
        end
    endtask

    always @(negedge CLK) begin
        if (!reset) begin
            for (int b = 0; b < num_banks; b++) begin
                check_bank(b);
            end
            record_request();
        end
    end

    assert property (@(posedge CLK) disable iff (reset)
        block_status == $past(ram_mem_complete & (ram_mem_ren | ram_mem_wen)))
        else begin
            errors++;
            $display("Completion pulse did not come one cycle after the RAM finished");
        end

    assert property (@(posedge CLK) disable iff (reset)
        dp_out_flushed |=> (ram_mem_ren == '0) && (ram_mem_wen == '0))
        else begin
            errors++;
            $display("RAM strobe after the cache reported flushed");
        end

    // ======================================================================
    // Clock, sequence and timeout
    // ======================================================================

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        reset = 1'b1;
        mem_in = 1'b0;
        mem_in_addr = '0;
        mem_in_rw_mode = 1'b0;
        mem_in_store_value = '0;
        dp_in_halt = 1'b0;
        hold = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = (base_addr + 32'(i * 4)) ^ fill_key;
        end
        repeat (3) @(posedge CLK);
        reset <= 1'b0;
        @(negedge CLK);
        assert (!stall && block_status == '0 && ram_mem_ren == '0 && ram_mem_wen == '0 &&
                !dp_out_flushed) else begin
            errors++;
            $display("FAIL reset state: stall %h block_status %h ram_mem_ren %h",
                     stall, block_status, ram_mem_ren);
            $display("FAIL reset state: ram_mem_wen %h dp_out_flushed %h expected 0",
                     ram_mem_wen, dp_out_flushed);
        end
        for (int n = 0; n < num_requests; n++) begin
            @(posedge CLK);
            // Holding bank 1 fills its MSHR so that stall rises
            hold <= (n >= hold_start && n < hold_end) ? 2'b10 : 2'b00;
            if (!was_dropped) begin
                drive_request(n >= hold_start && n < hold_end);
            end
        end
        @(posedge CLK);
        mem_in <= 1'b0;
        dp_in_halt <= 1'b1;
        do @(negedge CLK); while (!dp_out_flushed);
        repeat (10) @(posedge CLK);
        $display("Errors: %0d request side, %0d RAM side", errors, ram_errors);
        if (errors == 0 && ram_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout after %0d cycles without the cache reporting flushed", cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* bench/ram_model.sv */
module ram_model #(
    parameter int num_banks = 2,
    parameter logic [31:0] fill_key = 32'h3c5a_96e1
) (
    input logic CLK,
    input logic reset,
    input logic [num_banks-1:0] hold,
    input logic [num_banks-1:0] ram_mem_ren,
    input logic [num_banks-1:0] ram_mem_wen,
    input logic [num_banks-1:0][31:0] ram_mem_addr,
    input logic [num_banks-1:0][31:0] ram_mem_store,
    output logic [num_banks-1:0][31:0] ram_mem_data,
    output logic [num_banks-1:0] ram_mem_complete,
    output int errors
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] lfsr_state = 32'hb348_04d0;
    logic [num_banks-1:0] busy;
    logic [1:0] wait_left [num_banks];

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : (addr ^ fill_key);
    endfunction

    initial begin
        errors = 0;
        ram_mem_complete = '0;
        ram_mem_data = '0;
    end

    // Each bank waits 0 to 3 extra cycles, and a held bank makes no progress
    always @(posedge CLK) begin
        for (int b = 0; b < num_banks; b++) begin
            if (reset) begin
                ram_mem_complete[b] <= 1'b0;
                busy[b] <= 1'b0;
            end else if (ram_mem_complete[b]) begin
                ram_mem_complete[b] <= 1'b0;
                busy[b] <= 1'b0;
            end else if ((ram_mem_ren[b] || ram_mem_wen[b]) && !hold[b]) begin
                if (!busy[b]) begin
                    busy[b] <= 1'b1;
                    wait_left[b] <= 2'(take_bits(2));
                end else if (wait_left[b] == 2'd0) begin
                    ram_mem_complete[b] <= 1'b1;
                    ram_mem_data[b] <= read_word(ram_mem_addr[b]);
                    if (ram_mem_wen[b]) begin
                        mem[ram_mem_addr[b]] = ram_mem_store[b];
                    end
                end else begin
                    wait_left[b] <= wait_left[b] - 2'd1;
                end
            end
        end
    end

    for (genvar b = 0; b < num_banks; b++) begin : check_gen
        assert property (@(posedge CLK) disable iff (reset)
            (ram_mem_ren[b] || ram_mem_wen[b]) && !ram_mem_complete[b] |=>
            (ram_mem_ren[b] || ram_mem_wen[b]) && $stable(ram_mem_wen[b]) &&
            $stable(ram_mem_addr[b]))
            else begin
                errors++;
                $display("RAM request on bank %0d changed or dropped before completion", b);
            end
        assert property (@(posedge CLK) disable iff (reset)
            ram_mem_complete[b] |-> ram_mem_ren[b] || ram_mem_wen[b])
            else begin
                errors++;
                $display("Strobe on bank %0d fell while completion was still high", b);
            end
    end

endmodule

/* project.f */
source/cache_pkg.sv
source/mshr_if.sv
source/uuid_counter.sv
source/mshr_buffer.sv
source/bank_fsm.sv
source/cache_bank.sv
source/lockup_free_cache.sv
bench/ram_model.sv
bench/cache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f project.f --top-module cache_tb -o cache_sim

result=$(./obj_dir/cache_sim)
echo "$result"
echo "$result" | grep -qx "Simulation completed successfully"

/* source/bank_fsm.sv */
module bank_fsm (
    input logic CLK,
    input logic reset,
    input logic halt,
    mshr_if.fsm_side port,
    output logic ram_mem_ren,
    output logic ram_mem_wen,
    output cache_pkg::word_t ram_mem_addr,
    output cache_pkg::word_t ram_mem_store,
    input cache_pkg::word_t ram_mem_data,
    input logic ram_mem_complete,
    output logic done,
    output cache_pkg::mshr_entry_t done_entry,
    output cache_pkg::word_t done_data,
    output logic idle
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_request = 2'd1;
    localparam logic [1:0] st_respond = 2'd2;

    logic [1:0] state;
    cache_pkg::mshr_entry_t cur_entry;
    cache_pkg::word_t load_data;

    // ======================================================================
    // Control
    // ======================================================================

    assign idle = (state == st_idle);
    assign port.pop = idle && port.valid && !halt;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (port.pop) state <= st_request;
                st_request: if (ram_mem_complete) state <= st_respond;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (port.pop) begin
            cur_entry <= port.entry;
        end
        if (state == st_request && ram_mem_complete) begin
            load_data <= ram_mem_data;
        end
    end

    // RAM strobes stay up until the RAM reports completion
    assign ram_mem_ren = (state == st_request) && !cur_entry.rw_mode;
    assign ram_mem_wen = (state == st_request) && cur_entry.rw_mode;
    assign ram_mem_addr = cur_entry.addr.raw;
    assign ram_mem_store = cur_entry.store_value;

    assign done = (state == st_respond);
    assign done_entry = cur_entry;
    assign done_data = load_data;

    // The RAM may only finish a transfer that this FSM has started
    assert property (@(posedge CLK) disable iff (reset)
        ram_mem_complete |-> state == st_request)
        else $error("RAM completion with no transfer outstanding");

endmodule

/* source/cache_bank.sv */
module cache_bank (
    input logic CLK,
    input logic reset,
    input cache_pkg::addr_t lookup_addr,
    input logic read_req,
    mshr_if.bank_side port,
    output logic hit,
    output cache_pkg::word_t hit_data,
    input logic done,
    input cache_pkg::mshr_entry_t done_entry,
    input cache_pkg::word_t done_data
);

    localparam int num_sets = 2 ** cache_pkg::index_bits;

    logic [num_sets-1:0] valid;
    logic [cache_pkg::tag_bits-1:0] tags [num_sets];
    cache_pkg::word_t data [num_sets];

    logic [cache_pkg::index_bits-1:0] look_idx;
    logic [cache_pkg::index_bits-1:0] done_idx;
    logic done_tag_match;
    logic fill;
    logic write_update;

    assign port.lookup_addr = lookup_addr;

    // ======================================================================
    // Lookup
    // ======================================================================

    assign look_idx = lookup_addr.f.index;

    // A pending write to the same word forces the read into the MSHR
    assign hit = read_req && valid[look_idx] &&
                 (tags[look_idx] == lookup_addr.f.tag) && !port.write_match;
    assign hit_data = data[look_idx];

    // ======================================================================
    // Completion update
    // ======================================================================

    assign done_idx = done_entry.addr.f.index;
    assign done_tag_match = valid[done_idx] && (tags[done_idx] == done_entry.addr.f.tag);

    // Reads allocate; writes only refresh a line that already holds the word
    assign fill = done && !done_entry.rw_mode;
    assign write_update = done && done_entry.rw_mode && done_tag_match;

    always_ff @(posedge CLK) begin
        if (reset) begin
            valid <= '0;
        end else if (fill) begin
            valid[done_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            tags[done_idx] <= done_entry.addr.f.tag;
            data[done_idx] <= done_data;
        end else if (write_update) begin
            data[done_idx] <= done_entry.store_value;
        end
    end

endmodule

/* source/cache_pkg.sv */
package cache_pkg;

    // ======================================================================
    // Address geometry
    // ======================================================================

    parameter int byte_off_bits = 2;
    parameter int banks_len = 1;
    parameter int index_bits = 3;
    parameter int tag_bits = 32 - index_bits - banks_len - byte_off_bits;

    // Width of the miss tags handed back to the core
    parameter int uuid_size = 4;

    typedef logic [31:0] word_t;

    // The same word seen raw or split into its cache fields
    typedef union packed {
        word_t raw;
        struct packed {
            logic [tag_bits-1:0] tag;
            logic [index_bits-1:0] index;
            logic [banks_len-1:0] bank;
            logic [byte_off_bits-1:0] byte_off;
        } f;
    } addr_t;

    // ======================================================================
    // Outstanding miss, as held in the MSHR
    // ======================================================================

    typedef struct packed {
        addr_t addr;
        // High for a write, low for a read
        logic rw_mode;
        word_t store_value;
        logic [uuid_size-1:0] uuid;
    } mshr_entry_t;

endpackage

/* source/lockup_free_cache.sv */
module lockup_free_cache #(
    parameter int num_banks = 2,
    parameter int mshr_depth = 4
) (
    input logic CLK,
    input logic reset,
    input logic mem_in,
    input logic [31:0] mem_in_addr,
    input logic mem_in_rw_mode,
    input logic [31:0] mem_in_store_value,
    input logic dp_in_halt,
    output logic [cache_pkg::uuid_size-1:0] mem_out_uuid,
    output logic stall,
    output logic hit,
    output logic [31:0] hit_load,
    output logic [num_banks-1:0] block_status,
    output logic [num_banks-1:0][cache_pkg::uuid_size-1:0] uuid_block,
    output logic [num_banks-1:0][31:0] fill_load,
    output logic dp_out_flushed,
    output logic [num_banks-1:0] ram_mem_ren,
    output logic [num_banks-1:0] ram_mem_wen,
    output logic [num_banks-1:0][31:0] ram_mem_addr,
    output logic [num_banks-1:0][31:0] ram_mem_store,
    input logic [num_banks-1:0][31:0] ram_mem_data,
    input logic [num_banks-1:0] ram_mem_complete
);

    localparam int word_lsb = cache_pkg::byte_off_bits;

    cache_pkg::addr_t req_addr;
    cache_pkg::mshr_entry_t new_entry;
    logic [cache_pkg::banks_len-1:0] bank_sel;
    logic halt_banks;
    logic [num_banks-1:0] read_req;
    logic [num_banks-1:0] inflight_write;
    logic [num_banks-1:0] accept;
    logic [num_banks-1:0] bank_hit;
    logic [num_banks-1:0] bank_full;
    logic [num_banks-1:0] bank_empty;
    logic [num_banks-1:0] bank_idle;
    logic [num_banks-1:0] done;
    logic [num_banks-1:0][cache_pkg::uuid_size-1:0] bank_uuid;
    cache_pkg::word_t [num_banks-1:0] hit_data;
    cache_pkg::word_t [num_banks-1:0] done_data;
    cache_pkg::mshr_entry_t [num_banks-1:0] done_entry;

    assign req_addr.raw = mem_in_addr;
    assign bank_sel = req_addr.f.bank;

    assign new_entry.addr = req_addr;
    assign new_entry.rw_mode = mem_in_rw_mode;
    assign new_entry.store_value = mem_in_store_value;
    assign new_entry.uuid = mem_out_uuid;

    // Results of the addressed bank
    assign hit = bank_hit[bank_sel];
    assign hit_load = hit_data[bank_sel];
    assign stall = bank_full[bank_sel];
    assign mem_out_uuid = bank_uuid[bank_sel];

    // FSMs stop taking work once halted with nothing left queued
    assign halt_banks = dp_in_halt && (&bank_empty);
    assign dp_out_flushed = halt_banks && (&bank_idle);

    // ======================================================================
    // Banks
    // ======================================================================

    for (genvar i = 0; i < num_banks; i++) begin : bank_gen
        mshr_if port_i ();

        // The write the FSM is running also hides the array copy
        assign inflight_write[i] = !bank_idle[i] && done_entry[i].rw_mode &&
            (done_entry[i].addr.raw[31:word_lsb] == req_addr.raw[31:word_lsb]);
        assign read_req[i] = mem_in && !mem_in_rw_mode && (int'(bank_sel) == i) &&
                             !inflight_write[i];
        assign accept[i] = mem_in && (int'(bank_sel) == i) && !bank_hit[i] && !bank_full[i];

        assign block_status[i] = done[i];
        assign uuid_block[i] = done_entry[i].uuid;
        assign fill_load[i] = done_data[i];

        uuid_counter #(.mshr_depth(mshr_depth)) uuid_counter_i (
            .CLK(CLK), .reset(reset), .advance(accept[i]), .uuid(bank_uuid[i])
        );

        mshr_buffer #(.mshr_depth(mshr_depth)) mshr_buffer_i (
            .CLK(CLK), .reset(reset), .push(accept[i]), .push_entry(new_entry),
            .full(bank_full[i]), .empty(bank_empty[i]), .port(port_i)
        );

        bank_fsm bank_fsm_i (
            .CLK(CLK), .reset(reset), .halt(halt_banks), .port(port_i),
            .ram_mem_ren(ram_mem_ren[i]), .ram_mem_wen(ram_mem_wen[i]),
            .ram_mem_addr(ram_mem_addr[i]), .ram_mem_store(ram_mem_store[i]),
            .ram_mem_data(ram_mem_data[i]), .ram_mem_complete(ram_mem_complete[i]),
            .done(done[i]), .done_entry(done_entry[i]), .done_data(done_data[i]),
            .idle(bank_idle[i])
        );

        cache_bank cache_bank_i (
            .CLK(CLK), .reset(reset), .lookup_addr(req_addr), .read_req(read_req[i]),
            .port(port_i), .hit(bank_hit[i]), .hit_data(hit_data[i]),
            .done(done[i]), .done_entry(done_entry[i]), .done_data(done_data[i])
        );
    end

    assert property (@(posedge CLK) num_banks == 2 ** cache_pkg::banks_len)
        else $error("num_banks does not match the bank select width");

endmodule

/* source/mshr_buffer.sv */
module mshr_buffer #(
    parameter int mshr_depth = 4
) (
    input logic CLK,
    input logic reset,
    input logic push,
    input cache_pkg::mshr_entry_t push_entry,
    output logic full,
    output logic empty,
    mshr_if.buffer_side port
);

    localparam int ptr_bits = (mshr_depth > 1) ? $clog2(mshr_depth) : 1;
    localparam int cnt_bits = $clog2(mshr_depth + 1);
    localparam int word_lsb = cache_pkg::byte_off_bits;

    cache_pkg::mshr_entry_t entries [mshr_depth];
    logic [mshr_depth-1:0] live;
    logic [ptr_bits-1:0] head;
    logic [ptr_bits-1:0] tail;
    logic [cnt_bits-1:0] count;
    logic do_push;
    logic do_pop;

    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
        if (ptr == ptr_bits'(mshr_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == cnt_bits'(mshr_depth));
    assign empty = (count == '0);
    assign do_push = push && !full;
    assign do_pop = port.pop && !empty;

    assign port.valid = !empty;
    assign port.entry = entries[head];

    always_ff @(posedge CLK) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            live <= '0;
        end else begin
            if (do_push) begin
                tail <= next_ptr(tail);
                live[tail] <= 1'b1;
            end
            if (do_pop) begin
                head <= next_ptr(head);
                live[head] <= 1'b0;
            end
            count <= count + cnt_bits'(do_push) - cnt_bits'(do_pop);
        end
    end

    always_ff @(posedge CLK) begin
        if (do_push) begin
            entries[tail] <= push_entry;
        end
    end

    // A queued write to the looked-up word makes the array copy stale
    always_comb begin
        port.write_match = 1'b0;
        for (int i = 0; i < mshr_depth; i++) begin
            if (live[i] && entries[i].rw_mode &&
                entries[i].addr.raw[31:word_lsb] == port.lookup_addr.raw[31:word_lsb]) begin
                port.write_match = 1'b1;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (reset) push |-> !full)
        else $error("push into a full MSHR");
    assert property (@(posedge CLK) disable iff (reset) port.pop |-> !empty)
        else $error("pop from an empty MSHR");

endmodule

/* source/mshr_if.sv */
interface mshr_if;

    logic valid;
    cache_pkg::mshr_entry_t entry;
    logic pop;
    logic write_match;
    cache_pkg::addr_t lookup_addr;

    modport buffer_side (
        output valid, entry, write_match,
        input pop, lookup_addr
    );

    modport fsm_side (
        input valid, entry,
        output pop
    );

    modport bank_side (
        input write_match,
        output lookup_addr
    );

endinterface

/* source/uuid_counter.sv */
module uuid_counter #(
    parameter int mshr_depth = 4
) (
    input logic CLK,
    input logic reset,
    input logic advance,
    output logic [cache_pkg::uuid_size-1:0] uuid
);

    // Next tag to hand out, wrapping around
    always_ff @(posedge CLK) begin
        if (reset) begin
            uuid <= '0;
        end else if (advance) begin
            uuid <= uuid + 1'b1;
        end
    end

    // Every queued miss plus the one held by the FSM must carry a distinct tag
    assert property (@(posedge CLK)
        mshr_depth + 1 <= 2 ** cache_pkg::uuid_size)
        else $error("uuid space too small for the MSHR depth");

endmodule
